//--- source/adc16_pkg.sv
// ADC16 board-control package: OPB bus structs, control structs, address map and sizes.

package adc16_pkg;

  // ======================================================================
  // Address map
  // ======================================================================
  localparam logic [31:0] OPB_BASEADDR = 32'h0002_0000;  // Slave window start.
  localparam logic [31:0] OPB_HIGHADDR = 32'h0002_00FF;  // Slave window end, 64 words.

  localparam int WORD_3WIRE     = 0;   // 3-wire pins, status readback.
  localparam int WORD_CTRL      = 1;   // Reset, snap request, bitslip, delay tap.
  localparam int WORD_STROBE    = 2;   // One delay-load strobe per lane.
  localparam int WORD_STATUS    = 3;   // Snapshot done in bit 0.
  localparam int WORD_SNAP_BASE = 16;  // Words 16..31 read the sample buffer.

  // ======================================================================
  // Sizes
  // ======================================================================
  localparam int NUM_CHIPS  = 8;   // ADC chips, one bitslip each.
  localparam int NUM_LANES  = 32;  // Data lanes, four per chip.
  localparam int TAP_W      = 5;   // IDELAY tap width.
  localparam int SNAP_DEPTH = 16;  // Snapshot buffer words.
  localparam int SNAP_AW    = 4;   // Snapshot buffer address width.

  // Register bit positions, little-endian (bit 0 is the LSB of the 32-bit word).
  // OPB numbers bits big-endian, so OPB bit n is bit 31-n here.
  localparam int W3_CSN_LSB       = 0;   // Chip selects A..H in bits 7:0, active high.
  localparam int W3_SDATA_BIT     = 8;   // Shared serial data.
  localparam int W3_SCLK_BIT      = 9;   // Shared serial clock.
  localparam int CTRL_TAP_LSB     = 0;   // Delay tap in bits 4:0.
  localparam int CTRL_BITSLIP_LSB = 8;   // Bitslip chip A..H in bits 15:8.
  localparam int CTRL_SNAP_BIT    = 16;  // Snapshot request (OPB bit 15).
  localparam int CTRL_RESET_BIT   = 20;  // ADC reset (OPB bit 11).

  // ======================================================================
  // Bus and control structs
  // ======================================================================
  typedef struct packed {
    logic [31:0] abus;      // Byte address.
    logic [3:0]  be;        // Byte enables, be[i] covers dbus[8*i+7:8*i].
    logic [31:0] dbus;      // Write data.
    logic        rnw;       // 1 = read.
    logic        select;    // Transfer request.
    logic        seq_addr;  // Burst hint, not used by this slave.
  } opb_req_t;

  typedef struct packed {
    logic [31:0] dbus;      // Read data, zero outside the ack cycle.
    logic        err_ack;
    logic        retry;
    logic        tout_sup;
    logic        xfer_ack;  // One-cycle transfer acknowledge.
  } opb_rsp_t;

  typedef struct packed {
    logic       sclk;
    logic       sdata;
    logic [3:0] csn;        // Active low, csn[0] is chip 1 of the board.
  } adc3wire_t;

  typedef struct packed {
    logic                 reset;      // ADC reset level.
    logic                 snap_req;   // Rising edge arms a snapshot.
    logic [NUM_CHIPS-1:0] bitslip;    // Rising edge slips that chip.
    logic [TAP_W-1:0]     delay_tap;  // Shared tap for strobed lanes.
  } adc16_ctrl_t;

  typedef struct packed {
    logic [1:0] locked;      // Line clock lock per board.
    logic [1:0] roach2_rev;  // Board revision.
    logic [3:0] num_units;   // Supported ADC chips.
  } adc16_status_t;

endpackage

//--- source/opb_adc16_controller.sv
// OPB slave for the ADC16 control words: decode, byte-enabled registers, read mux, acknowledge.

`timescale 1ns/1ps

module opb_adc16_controller
  import adc16_pkg::*;
(
  input  logic                 OPB_Clk,
  input  logic                 rst_n,
  input  opb_req_t             opb_req,       // Master request.
  input  adc16_status_t        status,        // Board status for word 0.
  input  logic [31:0]          snap_rdata,    // Buffer word at snap_raddr.
  input  logic                 snap_done,     // Snapshot complete.
  output opb_rsp_t             opb_rsp,       // Slave response.
  output adc3wire_t            adc0_3wire,    // Board 0 programming pins.
  output adc3wire_t            adc1_3wire,    // Board 1 programming pins.
  output adc16_ctrl_t          ctrl,          // Decoded word 1.
  output logic [NUM_LANES-1:0] delay_strobe,  // Word 2 levels.
  output logic [SNAP_AW-1:0]   snap_raddr     // Buffer read address.
);

  // ======================================================================
  // Address decode
  // ======================================================================
  logic [31:0] offset;       // Byte offset inside the window.
  logic [4:0]  word;         // Word index 0..31.
  logic        addr_match;   // Address inside the window.
  logic        word_mapped;  // Words 0..3 and 16..31 only.
  logic        start;        // Accepted transfer this cycle.

  logic        ack_q;        // Transfer acknowledge.
  logic [31:0] rdata_q;      // Read data held for the ack cycle.
  logic [31:0] w3wire_q;     // Word 0.
  logic [31:0] ctrl_q;       // Word 1.
  logic [31:0] strobe_q;     // Word 2.
  logic [31:0] rd_word;      // Read mux output.

  assign offset     = opb_req.abus - OPB_BASEADDR;
  assign word       = offset[6:2];
  assign addr_match = (opb_req.abus >= OPB_BASEADDR) && (opb_req.abus <= OPB_HIGHADDR);

  // Upper offset bits must be clear, words 4..15 are a hole.
  assign word_mapped = (offset[31:7] == '0) &&
                       ((word <= WORD_STATUS) || (word >= WORD_SNAP_BASE));

  // No new transfer in the ack cycle, so ack lasts one cycle.
  assign start = opb_req.select && addr_match && word_mapped && !ack_q;

  // Buffer index is the low bits of words 16..31.
  assign snap_raddr = word[SNAP_AW-1:0];

  // Merge enabled bytes of new data into an old word.
  function automatic logic [31:0] be_merge(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];  // Byte lane i.
    end
    return res;
  endfunction

  // ======================================================================
  // Read mux
  // ======================================================================
  always_comb begin
    rd_word = '0;
    if (word == WORD_3WIRE) begin
      // Status sits above the low half of the 3-wire register.
      rd_word = {6'b0, status.locked, status.num_units, 2'b0, status.roach2_rev,
                 w3wire_q[15:0]};
    end else if (word == WORD_CTRL) begin
      rd_word = ctrl_q;
    end else if (word == WORD_STROBE) begin
      rd_word = strobe_q;
    end else if (word == WORD_STATUS) begin
      rd_word = {31'b0, snap_done};       // Done flag only.
    end else begin
      rd_word = snap_rdata;               // Snapshot buffer.
    end
  end

  // ======================================================================
  // Registers and acknowledge
  // ======================================================================
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      w3wire_q <= '0;   // All chip selects inactive.
      ctrl_q   <= '0;
      strobe_q <= '0;
    end else begin
      ack_q <= start;
      if (start && !opb_req.rnw) begin
        // Writes to word 3 and the buffer are acked and dropped.
        if (word == WORD_3WIRE) begin
          w3wire_q <= be_merge(w3wire_q, opb_req.dbus, opb_req.be);
        end else if (word == WORD_CTRL) begin
          ctrl_q <= be_merge(ctrl_q, opb_req.dbus, opb_req.be);
        end else if (word == WORD_STROBE) begin
          strobe_q <= be_merge(strobe_q, opb_req.dbus, opb_req.be);
        end
      end
    end
  end

  // Read value captured with the ack, zero for writes.
  always_ff @(posedge OPB_Clk) begin
    if (start) rdata_q <= opb_req.rnw ? rd_word : '0;
  end

  assign opb_rsp.dbus     = ack_q ? rdata_q : '0;  // Bus is OR-ed, so drive zero when idle.
  assign opb_rsp.err_ack  = 1'b0;
  assign opb_rsp.retry    = 1'b0;
  assign opb_rsp.tout_sup = 1'b0;
  assign opb_rsp.xfer_ack = ack_q;

  // ======================================================================
  // Output decode
  // ======================================================================
  // Both boards share clock and data.
  assign adc0_3wire.sclk  = w3wire_q[W3_SCLK_BIT];
  assign adc0_3wire.sdata = w3wire_q[W3_SDATA_BIT];
  assign adc1_3wire.sclk  = w3wire_q[W3_SCLK_BIT];
  assign adc1_3wire.sdata = w3wire_q[W3_SDATA_BIT];

  // Chips A..D on board 0, E..H on board 1, inverted to active low.
  assign adc0_3wire.csn = ~w3wire_q[W3_CSN_LSB +: 4];
  assign adc1_3wire.csn = ~w3wire_q[W3_CSN_LSB + 4 +: 4];

  assign ctrl.reset     = ctrl_q[CTRL_RESET_BIT];
  assign ctrl.snap_req  = ctrl_q[CTRL_SNAP_BIT];
  assign ctrl.bitslip   = ctrl_q[CTRL_BITSLIP_LSB +: NUM_CHIPS];
  assign ctrl.delay_tap = ctrl_q[CTRL_TAP_LSB +: TAP_W];

  assign delay_strobe = strobe_q;  // One strobe per lane.

endmodule

//--- source/adc16_lane_tuning.sv
// Lane tuning: edge detect of bitslip and strobe bits, bitslip pulses, per-lane delay taps.

`timescale 1ns/1ps

module adc16_lane_tuning
  import adc16_pkg::*;
(
  input  logic                             OPB_Clk,
  input  logic                             rst_n,
  input  adc16_ctrl_t                      ctrl,           // Bitslip levels and tap value.
  input  logic [NUM_LANES-1:0]             delay_strobe,   // Strobe levels.
  output logic [NUM_CHIPS-1:0]             bitslip_pulse,  // One cycle per rising bit.
  output logic [NUM_LANES-1:0][TAP_W-1:0]  lane_tap        // Held tap per lane.
);

  // ======================================================================
  // Edge detection
  // ======================================================================
  logic [NUM_CHIPS-1:0] bitslip_q;  // Previous bitslip levels.
  logic [NUM_LANES-1:0] strobe_q;   // Previous strobe levels.
  logic [NUM_CHIPS-1:0] slip_rise;  // Rising bitslip bits.
  logic [NUM_LANES-1:0] load_rise;  // Rising strobe bits.

  assign slip_rise = ctrl.bitslip & ~bitslip_q;
  assign load_rise = delay_strobe & ~strobe_q;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      bitslip_q <= '0;
      strobe_q  <= '0;
    end else begin
      bitslip_q <= ctrl.bitslip;
      strobe_q  <= delay_strobe;
    end
  end

  // ======================================================================
  // Bitslip pulses
  // ======================================================================
  // Registered, so the pulse follows the write ack by one cycle.
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      bitslip_pulse <= '0;
    end else begin
      bitslip_pulse <= slip_rise;  // Level held high gives one pulse only.
    end
  end

  // ======================================================================
  // Delay taps
  // ======================================================================
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_tap <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        // Shared tap lands only on lanes whose strobe just rose.
        if (load_rise[i]) lane_tap[i] <= ctrl.delay_tap;
      end
    end
  end

endmodule

//--- source/adc16_snapshot.sv
// Snapshot capture: request edge detect, write counter, 16-word sample buffer, done flag.

`timescale 1ns/1ps

module adc16_snapshot
  import adc16_pkg::*;
(
  input  logic               OPB_Clk,
  input  logic               rst_n,
  input  logic               snap_req,      // Level from the control word.
  input  logic [31:0]        sample,        // ADC sample word.
  input  logic               sample_valid,  // Sample qualifier.
  input  logic [SNAP_AW-1:0] raddr,         // Buffer read address.
  output logic [31:0]        rdata,         // Buffer word, asynchronous read.
  output logic               done           // Buffer full.
);

  // ======================================================================
  // Capture control
  // ======================================================================
  logic               req_q;    // Previous request level.
  logic               armed;    // Capture in progress.
  logic [SNAP_AW-1:0] wr_cnt;   // Next buffer slot.
  logic               start;    // Request rising this cycle.
  logic               capture;  // Store the sample this cycle.
  logic [SNAP_AW-1:0] wr_addr;  // Slot for this sample.
  logic               last;     // This sample fills the buffer.

  logic [31:0] mem [SNAP_DEPTH];  // Sample buffer.

  assign start   = snap_req && !req_q;
  assign capture = (armed || start) && sample_valid;  // First sample may arrive on the rise.
  assign wr_addr = start ? '0 : wr_cnt;               // A new request restarts at slot 0.
  assign last    = (wr_addr == SNAP_AW'(SNAP_DEPTH - 1));

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      armed  <= 1'b0;
      wr_cnt <= '0;
      done   <= 1'b0;
    end else begin
      req_q <= snap_req;
      if (start) begin
        armed  <= 1'b1;  // Arm.
        done   <= 1'b0;  // Old contents are stale.
        wr_cnt <= '0;
      end
      if (capture) begin
        wr_cnt <= wr_addr + 1'b1;
        if (last) begin
          armed <= 1'b0;  // Stop after SNAP_DEPTH valid samples.
          done  <= 1'b1;
        end
      end
    end
  end

  // ======================================================================
  // Sample buffer
  // ======================================================================
  // Only valid samples are written, so the buffer holds a gap-free run.
  always_ff @(posedge OPB_Clk) begin
    if (capture) mem[wr_addr] <= sample;
  end

  assign rdata = mem[raddr];  // Read on the same cycle as the bus decode.

endmodule

//--- source/adc16_top.sv
// ADC16 control top level: OPB controller, lane tuning and snapshot.

`timescale 1ns/1ps

module adc16_top
  import adc16_pkg::*;
(
  input  logic                            OPB_Clk,
  input  logic                            rst_n,
  input  opb_req_t                        opb_req,              // OPB master request.
  input  adc16_status_t                   status,               // Board status.
  input  logic [31:0]                     adc16_sample,         // Snapshot sample.
  input  logic                            adc16_sample_valid,   // Sample qualifier.
  output opb_rsp_t                        opb_rsp,              // OPB slave response.
  output adc3wire_t                       adc0_3wire,           // Board 0 programming.
  output adc3wire_t                       adc1_3wire,           // Board 1 programming.
  output logic                            adc16_reset,          // ADC reset level.
  output logic [NUM_CHIPS-1:0]            adc16_bitslip_pulse,  // ISERDES bitslip.
  output logic [NUM_LANES-1:0][TAP_W-1:0] adc16_lane_tap        // IDELAY taps.
);

  // ======================================================================
  // Internal wiring
  // ======================================================================
  adc16_ctrl_t          ctrl;          // Decoded control word.
  logic [NUM_LANES-1:0] delay_strobe;  // Strobe levels.
  logic [SNAP_AW-1:0]   snap_raddr;    // Buffer read address.
  logic [31:0]          snap_rdata;    // Buffer read data.
  logic                 snap_done;     // Snapshot complete.

  assign adc16_reset = ctrl.reset;

  opb_adc16_controller i_controller (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .opb_req      (opb_req),
    .status       (status),
    .snap_rdata   (snap_rdata),
    .snap_done    (snap_done),
    .opb_rsp      (opb_rsp),
    .adc0_3wire   (adc0_3wire),
    .adc1_3wire   (adc1_3wire),
    .ctrl         (ctrl),
    .delay_strobe (delay_strobe),
    .snap_raddr   (snap_raddr)
  );

  adc16_lane_tuning i_lane_tuning (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .delay_strobe  (delay_strobe),
    .bitslip_pulse (adc16_bitslip_pulse),
    .lane_tap      (adc16_lane_tap)
  );

  adc16_snapshot i_snapshot (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .snap_req     (ctrl.snap_req),
    .sample       (adc16_sample),
    .sample_valid (adc16_sample_valid),
    .raddr        (snap_raddr),
    .rdata        (snap_rdata),
    .done         (snap_done)
  );

endmodule

//--- tests/adc16_top_sva.sv
// Bound assertions for the ADC16 top level: OPB acknowledge rules and chip-select reset state.

`timescale 1ns/1ps

module adc16_top_sva
  import adc16_pkg::*;
(
  input logic      OPB_Clk,
  input logic      rst_n,
  input opb_req_t  opb_req,     // Master request.
  input opb_rsp_t  opb_rsp,     // Slave response.
  input adc3wire_t adc0_3wire,  // Board 0 pins.
  input adc3wire_t adc1_3wire   // Board 1 pins.
);

  logic outside;       // Request address outside the slave window.
  int   fail_cnt = 0;  // Count of failed assertions.

  assign outside = (opb_req.abus < OPB_BASEADDR) || (opb_req.abus > OPB_HIGHADDR);

  // ======================================================================
  // OPB acknowledge rules
  // ======================================================================
  ack_one_cycle: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    opb_rsp.xfer_ack |=> !opb_rsp.xfer_ack)
    else begin
      $error("xfer_ack stayed high for two cycles");
      fail_cnt++;
    end

  dbus_idle_zero: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !opb_rsp.xfer_ack |-> (opb_rsp.dbus == '0))
    else begin
      $error("Response dbus not zero outside the ack cycle");
      fail_cnt++;
    end

  no_ack_outside: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    (opb_req.select && outside) |=> !opb_rsp.xfer_ack)
    else begin
      $error("Acknowledge after a request outside the window");
      fail_cnt++;
    end

  // Chip selects are active low, so reset must leave them all high.
  csn_in_reset: assert property (@(posedge OPB_Clk)
    !rst_n |-> ((adc0_3wire.csn == 4'hF) && (adc1_3wire.csn == 4'hF)))
    else begin
      $error("Chip select active during reset");
      fail_cnt++;
    end

endmodule

bind adc16_top adc16_top_sva i_adc16_top_sva (
  .OPB_Clk    (OPB_Clk),
  .rst_n      (rst_n),
  .opb_req    (opb_req),
  .opb_rsp    (opb_rsp),
  .adc0_3wire (adc0_3wire),
  .adc1_3wire (adc1_3wire)
);

//--- tests/tb_adc16_top.sv
// Testbench for the ADC16 top level: OPB bus tasks, register model, compare tasks, six behaviors.

`timescale 1ns/1ps

module tb_adc16_top
  import adc16_pkg::*;
();

  logic                            OPB_Clk;
  logic                            rst_n;
  opb_req_t                        opb_req;
  adc16_status_t                   status;
  logic [31:0]                     adc16_sample;
  logic                            adc16_sample_valid;
  opb_rsp_t                        opb_rsp;
  adc3wire_t                       adc0_3wire;
  adc3wire_t                       adc1_3wire;
  logic                            adc16_reset;
  logic [NUM_CHIPS-1:0]            adc16_bitslip_pulse;
  logic [NUM_LANES-1:0][TAP_W-1:0] adc16_lane_tap;

  logic [31:0]      m_w3, m_ctrl, m_strobe;  // Model of words 0..2.
  logic [TAP_W-1:0] exp_tap [NUM_LANES];     // Expected tap per lane.
  int               pulse_cnt [NUM_CHIPS];   // Bitslip pulses seen per chip.
  logic [31:0]      pattern;                 // Next sample value.
  logic             snap_watch;              // Waiting for the ack that raises snap_req.
  logic             snap_track;              // Looking for the first captured sample.
  logic [31:0]      exp_first;               // First sample the capture stores.
  integer           seed;
  integer           gap_seed;                // Separate stream for the valid gaps.

  adc16_top i_adc16_top (
    .OPB_Clk (OPB_Clk), .rst_n (rst_n), .opb_req (opb_req), .status (status),
    .adc16_sample (adc16_sample), .adc16_sample_valid (adc16_sample_valid),
    .opb_rsp (opb_rsp), .adc0_3wire (adc0_3wire), .adc1_3wire (adc1_3wire),
    .adc16_reset (adc16_reset), .adc16_bitslip_pulse (adc16_bitslip_pulse),
    .adc16_lane_tap (adc16_lane_tap)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;  // 10 ns period.
  end

  // ======================================================================
  // Reference model and compare tasks
  // ======================================================================
  function automatic logic [31:0] ref_read(input int word);
    logic [31:0] val;
    val = '0;
    if (word == WORD_3WIRE) begin
      val[15:0]  = m_w3[15:0];          // Low half of the 3-wire register.
      val[17:16] = status.roach2_rev;
      val[23:20] = status.num_units;
      val[25:24] = status.locked;
    end else if (word == WORD_CTRL) begin
      val = m_ctrl;
    end else if (word == WORD_STROBE) begin
      val = m_strobe;
    end
    return val;
  endfunction

  // Expected pins of one board: shared clock and data, four inverted selects.
  function automatic adc3wire_t board_pins(input int board);
    adc3wire_t pins;
    pins.sclk  = m_w3[9];
    pins.sdata = m_w3[8];
    pins.csn   = ~m_w3[board*4 +: 4];
    return pins;
  endfunction

  task automatic model_write(input int word, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] mask;
    logic [31:0] next;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    next = '0;
    if (word == WORD_3WIRE) begin
      m_w3 = (m_w3 & ~mask) | (data & mask);
    end else if (word == WORD_CTRL) begin
      m_ctrl = (m_ctrl & ~mask) | (data & mask);
    end else if (word == WORD_STROBE) begin
      next = (m_strobe & ~mask) | (data & mask);
      for (int i = 0; i < NUM_LANES; i++) begin
        if (next[i] && !m_strobe[i]) exp_tap[i] = m_ctrl[TAP_W-1:0];  // Rising strobe loads.
      end
      m_strobe = next;
    end
  endtask

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_3wire(input string name, input adc3wire_t got, input adc3wire_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tap(input string name, input logic [TAP_W-1:0] got,
                           input logic [TAP_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ======================================================================
  // OPB bus tasks
  // ======================================================================
  task automatic opb_access(input logic [31:0] addr, input logic rnw, input logic [31:0] data,
                            input logic [3:0] be, output logic acked, output logic [31:0] rdata);
    int n;
    acked = 1'b0;
    rdata = '0;
    n     = 0;
    @(posedge OPB_Clk);
    opb_req.abus   <= addr;
    opb_req.rnw    <= rnw;
    opb_req.dbus   <= rnw ? 32'h0 : data;
    opb_req.be     <= be;
    opb_req.select <= 1'b1;
    while (!acked && n < 8) begin  // Ack limit of 8 cycles.
      @(negedge OPB_Clk);
      check_word("opb_rsp err_ack retry tout_sup",
                 {29'b0, opb_rsp.err_ack, opb_rsp.retry, opb_rsp.tout_sup}, 32'h0);
      if (opb_rsp.xfer_ack) begin
        acked = 1'b1;
        rdata = opb_rsp.dbus;
      end
      n++;
    end
    @(posedge OPB_Clk);
    opb_req.select <= 1'b0;
  endtask

  task automatic opb_write(input int word, input logic [31:0] data, input logic [3:0] be);
    logic        acked;
    logic [31:0] rd;
    opb_access(OPB_BASEADDR + 32'(word * 4), 1'b0, data, be, acked, rd);
    if (!acked) begin
      $display("No acknowledge within 8 cycles for a write to word %0d", word);
      stop_run();
    end
    model_write(word, data, be);
  endtask

  task automatic opb_read(input int word, output logic [31:0] data);
    logic acked;
    opb_access(OPB_BASEADDR + 32'(word * 4), 1'b1, 32'h0, 4'hF, acked, data);
    if (!acked) begin
      $display("No acknowledge within 8 cycles for a read of word %0d", word);
      stop_run();
    end
  endtask

  // ======================================================================
  // Sample source and bitslip monitor
  // ======================================================================
  always @(posedge OPB_Clk) begin
    if (!rst_n) begin
      adc16_sample_valid <= 1'b0;
    end else if (($random(gap_seed) & 3) != 0) begin  // Valid about three cycles in four.
      adc16_sample       <= pattern;
      adc16_sample_valid <= 1'b1;
      pattern            <= pattern + 1;
    end else begin
      adc16_sample_valid <= 1'b0;
    end
  end

  always @(negedge OPB_Clk) begin
    for (int i = 0; i < NUM_CHIPS; i++) begin
      if (adc16_bitslip_pulse[i]) pulse_cnt[i] = pulse_cnt[i] + 1;
    end
  end

  // The capture starts on the edge after the request ack, so the first valid
  // sample seen from that ack cycle on is the first one stored.
  always @(negedge OPB_Clk) begin
    if (snap_watch && opb_rsp.xfer_ack) begin
      snap_watch = 1'b0;
      snap_track = 1'b1;
    end
    if (snap_track && adc16_sample_valid) begin
      exp_first  = adc16_sample;
      snap_track = 1'b0;
    end
  end

  initial begin
    #20000;  // About four times the test length.
    $display("Watchdog expired before the tests finished");
    stop_run();
  end

  // ======================================================================
  // Behaviors
  // ======================================================================
  initial begin
    logic [31:0]      rnd, data, rd;
    logic [3:0]       be;
    logic [TAP_W-1:0] tap;
    logic             acked, done;
    int               chip, polls;
    seed = 31931;
    gap_seed = seed + 1;
    rst_n = 1'b1;
    opb_req = '0;
    status = '0;
    adc16_sample = '0;
    adc16_sample_valid = 1'b0;
    pattern = 32'h0000_1000;
    snap_watch = 1'b0;
    snap_track = 1'b0;
    exp_first = '0;
    m_w3 = '0;
    m_ctrl = '0;
    m_strobe = '0;
    for (int i = 0; i < NUM_LANES; i++) exp_tap[i] = '0;
    for (int i = 0; i < NUM_CHIPS; i++) pulse_cnt[i] = 0;
    #1 rst_n = 1'b0;  // Falling edge applies the asynchronous reset.
    repeat (8) @(posedge OPB_Clk);
    rst_n <= 1'b1;

    // Reset state.
    @(negedge OPB_Clk);
    check_3wire("adc0_3wire", adc0_3wire, '{1'b0, 1'b0, 4'hF});
    check_3wire("adc1_3wire", adc1_3wire, '{1'b0, 1'b0, 4'hF});
    for (int i = 0; i < NUM_LANES; i++) check_tap("adc16_lane_tap", adc16_lane_tap[i], '0);
    opb_read(WORD_CTRL, rd);
    check_word("word 1", rd, 32'h0);
    opb_read(WORD_STROBE, rd);
    check_word("word 2", rd, 32'h0);

    // Byte-enabled writes, word 1 then word 2.
    repeat (8) begin
      data = $random(seed);
      rnd  = $random(seed);
      opb_write(WORD_CTRL, data, rnd[3:0]);
      opb_read(WORD_CTRL, rd);
      check_word("word 1", rd, ref_read(WORD_CTRL));
      check_word("adc16_reset", {31'b0, adc16_reset}, {31'b0, m_ctrl[20]});  // OPB bit 11.
      data = $random(seed);
      rnd  = $random(seed);
      opb_write(WORD_STROBE, data, rnd[3:0]);
      opb_read(WORD_STROBE, rd);
      check_word("word 2", rd, ref_read(WORD_STROBE));
    end

    // 3-wire pins and status readback.
    repeat (8) begin
      rnd = $random(seed);
      status <= rnd[7:0];
      data = $random(seed);
      opb_write(WORD_3WIRE, data, 4'hF);
      @(negedge OPB_Clk);
      check_3wire("adc0_3wire", adc0_3wire, board_pins(0));
      check_3wire("adc1_3wire", adc1_3wire, board_pins(1));
      opb_read(WORD_3WIRE, rd);
      check_word("word 0", rd, ref_read(WORD_3WIRE));
    end

    // Lane tuning, two rounds of tap loads.
    repeat (2) begin
      rnd = $random(seed);
      tap = rnd[TAP_W-1:0];
      opb_write(WORD_CTRL, {27'b0, tap}, 4'b0001);  // Tap in byte 0.
      opb_write(WORD_STROBE, 32'h0, 4'hF);          // Falling strobes load nothing.
      opb_write(WORD_STROBE, $random(seed), 4'hF);
      @(negedge OPB_Clk);
      for (int i = 0; i < NUM_LANES; i++) begin
        check_tap("adc16_lane_tap", adc16_lane_tap[i], exp_tap[i]);
      end
    end
    rnd  = $random(seed);
    chip = rnd[2:0];
    opb_write(WORD_CTRL, 32'h0, 4'b0010);  // All bitslip levels low.
    repeat (2) @(posedge OPB_Clk);
    for (int i = 0; i < NUM_CHIPS; i++) pulse_cnt[i] = 0;
    opb_write(WORD_CTRL, 32'(1) << (8 + chip), 4'b0010);
    @(negedge OPB_Clk);
    check_word("adc16_bitslip_pulse", 32'(adc16_bitslip_pulse), 32'(1) << chip);
    repeat (6) @(negedge OPB_Clk);  // Level held high, no further pulses.
    @(posedge OPB_Clk);
    for (int i = 0; i < NUM_CHIPS; i++) begin
      check_word("bitslip pulse count", 32'(pulse_cnt[i]), (i == chip) ? 32'd1 : 32'd0);
    end

    // Snapshot of the incrementing pattern.
    opb_write(WORD_CTRL, 32'h0, 4'b0100);  // Request low first.
    repeat (2) @(posedge OPB_Clk);
    snap_watch = 1'b1;  // Next ack belongs to the request write.
    opb_write(WORD_CTRL, 32'h0001_0000, 4'b0100);
    done  = 1'b0;
    polls = 0;
    while (!done && polls < 64) begin
      opb_read(WORD_STATUS, rd);
      done = rd[0];
      polls++;
    end
    if (!done) begin
      $display("Snapshot done flag never set in word 3");
      stop_run();
    end
    check_word("word 3", rd, 32'h1);
    for (int k = 0; k < SNAP_DEPTH; k++) begin
      opb_read(WORD_SNAP_BASE + k, rd);
      check_word("snapshot word", rd, exp_first + 32'(k));  // Gap-free run of valid samples.
    end

    // Unmapped accesses.
    opb_access(OPB_HIGHADDR + 32'h1, 1'b0, $random(seed), 4'hF, acked, rd);
    if (acked) begin
      $display("Write outside the address window was acknowledged");
      stop_run();
    end
    opb_access(OPB_BASEADDR + 32'd32, 1'b1, 32'h0, 4'hF, acked, rd);  // Word 8.
    if (acked) begin
      $display("Read of unmapped word 8 was acknowledged");
      stop_run();
    end
    for (int w = 0; w < 3; w++) begin
      opb_read(w, rd);
      check_word("register after unmapped access", rd, ref_read(w));
    end

    if (i_adc16_top.i_adc16_top_sva.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
source/adc16_pkg.sv
source/opb_adc16_controller.sv
source/adc16_lane_tuning.sv
source/adc16_snapshot.sv
source/adc16_top.sv
tests/adc16_top_sva.sv
tests/tb_adc16_top.sv
